// File: hdl/fpuSettings.svh
/* fpu adder build settings
   fraction precision, operand queue depth and credit counter width */

`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// 1 keeps the full 23-bit fraction, 0 truncates to 16 bits
`define FPU_FULL_PRECISION 0

// kept fraction width, hidden bit excluded
`define FPU_FRAC_BITS ((`FPU_FULL_PRECISION != 0) ? 23 : 16)

// operand queue entries, also the sender's starting credit count
`define FPU_QUEUE_DEPTH 4

// width of the credit counters
// must hold the queue depth, and as many output grants as the consumer may bank
`define FPU_CREDIT_BITS 3

`endif

// File: hdl/fpuOpPkg.sv
/* fpu arithmetic package
   opcode encoding and IEEE-754 single word field widths */

`default_nettype none

package fpuOpPkg;

	// arithmetic opcode carried with each operand pair
	typedef enum logic
	{
		opAdd = 1'b0,
		opSub = 1'b1
	} fpuOp_t;

	// word format, independent of the kept precision
	parameter int EXP_BITS = 8;
	parameter int FRAC_FIELD_BITS = 23;

	// sign sits above exponent and fraction
	parameter int SIGN_POS = EXP_BITS + FRAC_FIELD_BITS;

endpackage

`default_nettype wire

// File: hdl/fpuCtlPkg.sv
/* fpu control package
   issue FSM state encoding */

`default_nettype none

package fpuCtlPkg;

	// stIdle: pipeline empty
	// stRun: results in flight and moving
	// stHold: stage two waits for an output credit
	typedef enum logic [1:0]
	{
		stIdle = 2'd0,
		stRun = 2'd1,
		stHold = 2'd2
	} issueState_t;

endpackage

`default_nettype wire

// File: hdl/fpuOperandQueue.sv
/* operand queue
   circular FIFO of operand pairs and opcodes, filled under sender credits */

`timescale 1ns/1ps
`default_nettype none

`include "fpuSettings.svh"

module fpuOperandQueue
(
	input wire logic clock,
	input wire logic rst,
	input wire logic inValid,
	input wire logic [31:0] inA,
	input wire logic [31:0] inB,
	input wire fpuOpPkg::fpuOp_t inOp,
	input wire logic pop,
	output logic headValid,
	output logic [31:0] headA,
	output logic [31:0] headB,
	output fpuOpPkg::fpuOp_t headOp
);

	localparam int DEPTH = `FPU_QUEUE_DEPTH;
	localparam int PTR_BITS = $clog2(DEPTH);
	localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(DEPTH - 1);
	localparam logic [PTR_BITS:0] FULL_COUNT = (PTR_BITS + 1)'(DEPTH);

	// storage, no reset needed
	logic [31:0] memA [DEPTH];
	logic [31:0] memB [DEPTH];
	fpuOpPkg::fpuOp_t memOp [DEPTH];

	logic [PTR_BITS-1:0] wrPtr;
	logic [PTR_BITS-1:0] rdPtr;
	logic [PTR_BITS:0] count;

	// head of queue straight out of storage
	assign headValid = (count != '0);
	assign headA = memA[rdPtr];
	assign headB = memB[rdPtr];
	assign headOp = memOp[rdPtr];

	always_ff @(posedge clock)
	begin
		if (inValid)
		begin
			memA[wrPtr] <= inA;
			memB[wrPtr] <= inB;
			memOp[wrPtr] <= inOp;
		end
	end

	// pointers wrap at the last slot, count tracks occupancy
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (inValid)
				wrPtr <= (wrPtr == LAST_SLOT) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == LAST_SLOT) ? '0 : rdPtr + 1'b1;
			count <= count + (PTR_BITS + 1)'(inValid) - (PTR_BITS + 1)'(pop);
		end
	end

	// a write into a full queue means the sender spent a credit it did not hold
	assertNoOverflow: assert property (@(posedge clock) disable iff (rst)
		inValid |-> (count != FULL_COUNT));

	// control pops only a valid head
	assertNoUnderflow: assert property (@(posedge clock) disable iff (rst)
		pop |-> headValid);

endmodule

`default_nettype wire

// File: hdl/fpuAlignAdd.sv
/* fpu adder stage one
   unpacks, swaps, aligns and adds the truncated fractions */

`timescale 1ns/1ps
`default_nettype none

`include "fpuSettings.svh"

module fpuAlignAdd
(
	input wire logic clock,
	input wire logic advance,
	input wire logic [31:0] opA,
	input wire logic [31:0] opB,
	input wire fpuOpPkg::fpuOp_t op,
	output logic sumSign,
	output logic [8:0] sumExp,
	output logic [`FPU_FRAC_BITS+2:0] sumFrac
);

	localparam int FB = `FPU_FRAC_BITS;
	localparam int FW = FB + 3;
	localparam int SP = fpuOpPkg::SIGN_POS;
	localparam int FF = fpuOpPkg::FRAC_FIELD_BITS;

	logic signA;
	logic signB;
	logic [8:0] expA;
	logic [8:0] expB;
	logic [FW-1:0] fracA;
	logic [FW-1:0] fracB;

	// larger and smaller operand after the swap
	logic signL;
	logic signS;
	logic [8:0] expL;
	logic [8:0] expDiff;
	logic [FW-1:0] fracL;
	logic [FW-1:0] fracS;

	logic [FW-1:0] fracShift;
	logic [FW-1:0] fracAddend;
	logic [FW-1:0] fracSum;
	logic effSub;
	logic nextSign;
	logic [FW-1:0] nextFrac;

	always_comb
	begin
		// unpack, zero exponent counts as zero whatever the fraction holds
		signA = opA[SP];
		signB = opB[SP];
		expA = {1'b0, opA[SP-1:FF]};
		expB = {1'b0, opB[SP-1:FF]};
		fracA = (expA != '0) ? {2'b00, 1'b1, opA[FF-1 -: FB]} : '0;
		fracB = (expB != '0) ? {2'b00, 1'b1, opB[FF-1 -: FB]} : '0;

		// subtract flips B unless B is zero
		if ((op == fpuOpPkg::opSub) && (expB != '0))
			signB = !signB;

		// larger exponent leads
		if (expA >= expB)
		begin
			signL = signA;
			signS = signB;
			expL = expA;
			fracL = fracA;
			fracS = fracB;
			expDiff = expA - expB;
		end
		else
		begin
			signL = signB;
			signS = signA;
			expL = expB;
			fracL = fracB;
			fracS = fracA;
			expDiff = expB - expA;
		end

		// truncating align, shifts past the width leave zero
		fracShift = fracS >> expDiff;

		// ones' complement only when the smaller operand is nonzero
		effSub = (signL != signS) && fracS[FB];
		fracAddend = effSub ? ~fracShift : fracShift;
		fracSum = fracL + fracAddend;

		// top bit set means the smaller one won, fold back to magnitude
		nextSign = signL;
		nextFrac = fracSum;
		if (fracSum[FW-1])
		begin
			nextSign = !signL;
			nextFrac = ~fracSum;
		end
	end

	// stage register, frozen while the pipe stalls
	always_ff @(posedge clock)
	begin
		if (advance)
		begin
			sumSign <= nextSign;
			sumExp <= expL;
			sumFrac <= nextFrac;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fpuNormPack.sv
/* fpu adder stage two
   normalizes the sum, flushes underflow to zero and packs the word */

`timescale 1ns/1ps
`default_nettype none

`include "fpuSettings.svh"

module fpuNormPack
(
	input wire logic clock,
	input wire logic advance,
	input wire logic sumSign,
	input wire logic [8:0] sumExp,
	input wire logic [`FPU_FRAC_BITS+2:0] sumFrac,
	output logic [31:0] result
);

	localparam int FB = `FPU_FRAC_BITS;
	localparam int FW = FB + 3;
	localparam int FF = fpuOpPkg::FRAC_FIELD_BITS;
	localparam int EB = fpuOpPkg::EXP_BITS;

	logic [8:0] normExp;
	logic [FW-1:0] normFrac;
	logic [FF-1:0] fracField;
	logic flushZero;
	logic [31:0] packWord;

	always_comb
	begin
		normExp = sumExp;
		normFrac = sumFrac;

		// nothing left of the fraction, result is zero
		flushZero = (sumFrac == '0);

		if (sumFrac[FB+1])
		begin
			// carry out, one step right
			normExp = sumExp + 9'd1;
			normFrac = sumFrac >> 1;
		end
		else
		begin
			// left shift in power-of-two steps until the hidden bit is set
			if (normFrac[FB -: 16] == '0)
			begin
				normExp = normExp - 9'd16;
				normFrac = normFrac << 16;
			end
			if (normFrac[FB -: 8] == '0)
			begin
				normExp = normExp - 9'd8;
				normFrac = normFrac << 8;
			end
			if (normFrac[FB -: 4] == '0)
			begin
				normExp = normExp - 9'd4;
				normFrac = normFrac << 4;
			end
			if (normFrac[FB -: 2] == '0)
			begin
				normExp = normExp - 9'd2;
				normFrac = normFrac << 2;
			end
			if (!normFrac[FB])
			begin
				normExp = normExp - 9'd1;
				normFrac = normFrac << 1;
			end
		end

		// exponent wrapped below zero, or landed on zero
		if ((normExp[8:7] == 2'b11) || (normExp[EB-1:0] == '0))
			flushZero = 1'b1;

		// kept bits at the top of the field, low bits zero
		fracField = '0;
		fracField[FF-1 -: FB] = normFrac[FB-1:0];

		packWord = {sumSign, normExp[EB-1:0], fracField};
		if (flushZero)
			packWord = '0;
	end

	always_ff @(posedge clock)
	begin
		if (advance)
			result <= packWord;
	end

	// a loaded result with a zero exponent is always a clean positive zero
	assertZeroClean: assert property (@(posedge clock)
		advance |=> ((result[30:23] != 8'd0) || (result == 32'd0)));

endmodule

`default_nettype wire

// File: hdl/fpuAddControl.sv
/* fpu adder control
   issue, stage valid bits, pipeline hold and the credit counters */

`timescale 1ns/1ps
`default_nettype none

`include "fpuSettings.svh"

module fpuAddControl
(
	input wire logic clock,
	input wire logic rst,
	input wire logic headValid,
	input wire logic outCredit,
	output logic issue,
	output logic advance,
	output logic inCredit,
	output logic outValid
);

	localparam int CB = `FPU_CREDIT_BITS;
	localparam logic [CB-1:0] CREDIT_MAX = '1;

	logic stage1Valid;
	logic stage2Valid;
	logic stage1Next;
	logic stage2Next;
	logic [CB-1:0] creditCount;
	logic [CB-1:0] creditNext;
	fpuCtlPkg::issueState_t state;
	fpuCtlPkg::issueState_t stateNext;

	// the hold state stands for a stage-two result with no credit behind it
	assign advance = (state != fpuCtlPkg::stHold);
	assign issue = headValid && advance;

	// a result leaves only against a held credit
	assign outValid = stage2Valid && (creditCount != '0);

	always_comb
	begin
		stage1Next = stage1Valid;
		stage2Next = stage2Valid;
		if (advance)
		begin
			stage1Next = issue;
			stage2Next = stage1Valid;
		end

		// grant in, delivered result out
		creditNext = creditCount + CB'(outCredit) - CB'(outValid);

		// look ahead so the hold is ready at the next edge
		if (!stage1Next && !stage2Next)
			stateNext = fpuCtlPkg::stIdle;
		else if (stage2Next && (creditNext == '0))
			stateNext = fpuCtlPkg::stHold;
		else
			stateNext = fpuCtlPkg::stRun;
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			stage1Valid <= 1'b0;
			stage2Valid <= 1'b0;
			creditCount <= '0;
			state <= fpuCtlPkg::stIdle;
			inCredit <= 1'b0;
		end
		else
		begin
			stage1Valid <= stage1Next;
			stage2Valid <= stage2Next;
			creditCount <= creditNext;
			state <= stateNext;
			// each queue pop hands one credit back to the sender
			inCredit <= issue;
		end
	end

	// consumer must never grant past what the counter can hold
	assertCreditRange: assert property (@(posedge clock) disable iff (rst)
		(outCredit && !outValid) |-> (creditCount != CREDIT_MAX));

	// a leaving result must find the pipe moving or it would leave twice
	assertMovesOnSend: assert property (@(posedge clock) disable iff (rst)
		outValid |-> (state != fpuCtlPkg::stHold));

endmodule

`default_nettype wire

// File: hdl/fpuAddUnit.sv
/* fpu add/subtract unit
   credit-fed operand queue, control and two-stage datapath */

`timescale 1ns/1ps
`default_nettype none

`include "fpuSettings.svh"

module fpuAddUnit
(
	input wire logic clock,
	input wire logic rst,
	input wire logic inValid,
	input wire logic [31:0] inA,
	input wire logic [31:0] inB,
	input wire fpuOpPkg::fpuOp_t inOp,
	output logic inCredit,
	output logic outValid,
	output logic [31:0] outResult,
	input wire logic outCredit
);

	// queue head
	logic headValid;
	logic [31:0] headA;
	logic [31:0] headB;
	fpuOpPkg::fpuOp_t headOp;

	// pipeline steering
	logic issue;
	logic advance;

	// stage one register
	logic sumSign;
	logic [8:0] sumExp;
	logic [`FPU_FRAC_BITS+2:0] sumFrac;

	fpuOperandQueue u_fpuOperandQueue (
		.clock(clock),
		.rst(rst),
		.inValid(inValid),
		.inA(inA),
		.inB(inB),
		.inOp(inOp),
		.pop(issue),
		.headValid(headValid),
		.headA(headA),
		.headB(headB),
		.headOp(headOp)
	);

	fpuAddControl u_fpuAddControl (
		.clock(clock),
		.rst(rst),
		.headValid(headValid),
		.outCredit(outCredit),
		.issue(issue),
		.advance(advance),
		.inCredit(inCredit),
		.outValid(outValid)
	);

	// head feeds stage one directly, loaded on the issuing edge
	fpuAlignAdd u_fpuAlignAdd (
		.clock(clock),
		.advance(advance),
		.opA(headA),
		.opB(headB),
		.op(headOp),
		.sumSign(sumSign),
		.sumExp(sumExp),
		.sumFrac(sumFrac)
	);

	// stage two register is the unit output
	fpuNormPack u_fpuNormPack (
		.clock(clock),
		.advance(advance),
		.sumSign(sumSign),
		.sumExp(sumExp),
		.sumFrac(sumFrac),
		.result(outResult)
	);

endmodule

`default_nettype wire

// File: bench/fpuRefModel.svh
/* fpu adder reference model
   expected truncated add/subtract result, built from the format rules */

`ifndef FPU_REF_MODEL_SVH
`define FPU_REF_MODEL_SVH

function automatic logic [31:0] refAddSub(input logic [31:0] a, input logic [31:0] b,
	input logic isSub);
	int fb;
	int expA;
	int expB;
	int expOut;
	int shiftBy;
	logic signA;
	logic signB;
	logic signL;
	logic signOut;
	longint magA;
	longint magB;
	longint magL;
	longint magS;
	longint diff;
	longint mag;
	logic [22:0] fracOut;

	fb = `FPU_FRAC_BITS;
	signA = a[31];
	signB = b[31];
	expA = int'(a[30:23]);
	expB = int'(b[30:23]);

	// kept fraction with hidden bit, zero exponent means zero
	magA = (expA != 0) ? ((longint'(1) << fb) | longint'(a[22:0] >> (23 - fb))) : 0;
	magB = (expB != 0) ? ((longint'(1) << fb) | longint'(b[22:0] >> (23 - fb))) : 0;
	if (isSub && (expB != 0))
		signB = !signB;

	// larger exponent leads, ties go to a
	if (expA >= expB)
	begin
		signL = signA;
		expOut = expA;
		magL = magA;
		magS = magB;
		shiftBy = expA - expB;
	end
	else
	begin
		signL = signB;
		expOut = expB;
		magL = magB;
		magS = magA;
		shiftBy = expB - expA;
	end

	// signs of the swapped pair differ when the operands' signs differ
	if ((signA != signB) && (magS != 0))
	begin
		// ones' complement add loses one lsb when the leader wins
		diff = magL - ((shiftBy > 40) ? 0 : (magS >>> shiftBy));
		if (diff > 0)
		begin
			mag = diff - 1;
			signOut = signL;
		end
		else
		begin
			mag = -diff;
			signOut = !signL;
		end
	end
	else
	begin
		mag = magL + ((shiftBy > 40) ? 0 : (magS >>> shiftBy));
		signOut = signL;
	end

	if (mag == 0)
		return 32'h0;

	// renormalize onto the hidden bit
	if (mag >= (longint'(2) << fb))
	begin
		mag = mag >>> 1;
		expOut = expOut + 1;
	end
	while (mag < (longint'(1) << fb))
	begin
		mag = mag << 1;
		expOut = expOut - 1;
	end

	// underflow, or a carry out of the top exponent, gives zero
	if ((expOut <= 0) || (expOut >= 256))
		return 32'h0;

	fracOut = 23'((mag - (longint'(1) << fb)) << (23 - fb));
	return {signOut, 8'(expOut), fracOut};
endfunction

`endif

// File: bench/fpuAddUnitTb.sv
/* fpu add/subtract unit testbench
   credit-driven sender and consumer, scoreboard and assertion checks */

`timescale 1ns/1ps
`default_nettype none

`include "fpuSettings.svh"

module fpuAddUnitTb;

	localparam int DEPTH = `FPU_QUEUE_DEPTH;
	localparam int RANDOM_OPS = 200;
	// banked grants, both stages and a full queue
	localparam int HELD_OPS = 10;
	localparam int TOTAL_OPS = 9 + RANDOM_OPS + HELD_OPS;
	// worst case cycles per op while credits trickle in
	localparam int STALL_CYCLES = 30;
	localparam int HOLD_CYCLES = 20;
	localparam int WATCHDOG_CYCLES = TOTAL_OPS * STALL_CYCLES + HOLD_CYCLES + 200;

	`include "fpuRefModel.svh"

	logic clock;
	logic rst;
	logic inValid;
	logic [31:0] inA;
	logic [31:0] inB;
	fpuOpPkg::fpuOp_t inOp;
	logic inCredit;
	logic outValid;
	logic [31:0] outResult;
	logic outCredit;

	// scoreboard
	logic [31:0] expectQ[$];
	logic [31:0] expectHead;
	int expectCount;

	int senderCredits;
	int grantCount;
	int deliverCount;
	int returnCount;
	int opsSent;
	int errorCount;
	int testsRun;
	int testsFailed;
	int testErrors;
	logic creditMode;
	logic quietPhase;
	logic [31:0] seed;

	fpuAddUnit u_fpuAddUnit (
		.clock(clock),
		.rst(rst),
		.inValid(inValid),
		.inA(inA),
		.inB(inB),
		.inOp(inOp),
		.inCredit(inCredit),
		.outValid(outValid),
		.outResult(outResult),
		.outCredit(outCredit)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = !clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;

		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// sender credits, grants, deliveries and returns all counted at the edge
	always @(posedge clock)
	begin
		if (rst)
		begin
			senderCredits <= DEPTH;
			grantCount <= 0;
			deliverCount <= 0;
			returnCount <= 0;
		end
		else
		begin
			senderCredits <= senderCredits - int'(inValid) + int'(inCredit);
			if (outCredit)
				grantCount <= grantCount + 1;
			if (inCredit)
				returnCount <= returnCount + 1;
			if (outValid)
			begin
				deliverCount <= deliverCount + 1;
				if (expectQ.size() != 0)
					void'(expectQ.pop_front());
				expectCount = expectQ.size();
				expectHead = (expectCount != 0) ? expectQ[0] : 32'h0;
			end
		end
	end

	// free-running consumer keeps a few grants banked
	always @(posedge clock)
	begin
		#2;
		if (creditMode)
			outCredit = !rst && ((grantCount - deliverCount) < 4);
	end

	checkResult: assert property (@(posedge clock) disable iff (rst)
		outValid |-> (outResult == expectHead))
	else
	begin
		errorCount++;
		$display("Mismatch outResult: got %08h expected %08h",
			$sampled(outResult), $sampled(expectHead));
	end

	checkExpected: assert property (@(posedge clock) disable iff (rst)
		outValid |-> (expectCount != 0))
	else
	begin
		errorCount++;
		$display("result delivered with nothing expected");
	end

	// every result needs a grant that was not yet used
	checkGrantBound: assert property (@(posedge clock) disable iff (rst)
		outValid |-> (deliverCount < grantCount))
	else
	begin
		errorCount++;
		$display("result delivered beyond the granted output credits");
	end

	// every returned credit belongs to an operation already sent
	checkReturnBound: assert property (@(posedge clock) disable iff (rst)
		inCredit |-> (returnCount < opsSent))
	else
	begin
		errorCount++;
		$display("credit returned for an operation that was never sent");
	end

	checkSenderRange: assert property (@(posedge clock) disable iff (rst)
		(senderCredits >= 0) && (senderCredits <= DEPTH))
	else
	begin
		errorCount++;
		$display("sender credit count left its range: %0d", $sampled(senderCredits));
	end

	checkQuiet: assert property (@(posedge clock) disable iff (rst)
		quietPhase |-> (!outValid && !inCredit))
	else
	begin
		errorCount++;
		$display("outValid or inCredit active before any stimulus");
	end

	// push one operation once a sender credit is held
	task automatic sendOp(input logic [31:0] a, input logic [31:0] b,
		input fpuOpPkg::fpuOp_t op);
		while (senderCredits == 0)
		begin
			@(posedge clock);
			#2;
		end
		expectQ.push_back(refAddSub(a, b, op == fpuOpPkg::opSub));
		expectCount = expectQ.size();
		expectHead = expectQ[0];
		inValid = 1'b1;
		inA = a;
		inB = b;
		inOp = op;
		opsSent++;
		@(posedge clock);
		#2;
		inValid = 1'b0;
	endtask

	task automatic grantOne();
		outCredit = 1'b1;
		@(posedge clock);
		#2;
		outCredit = 1'b0;
	endtask

	// drain, then report the test
	task automatic finishTest(input string name);
		while ((deliverCount != opsSent) || (returnCount != opsSent))
			@(posedge clock);
		checkDrained: assert (expectQ.size() == 0)
		else
		begin
			errorCount++;
			$display("scoreboard still holds %0d results", expectQ.size());
		end
		testsRun++;
		if (errorCount != testErrors)
			testsFailed++;
		$display("test %s: %0d errors", name, errorCount - testErrors);
		testErrors = errorCount;
		#2;
	endtask

	initial
	begin
		logic [31:0] ra;
		logic [31:0] rb;

		rst = 1'b1;
		inValid = 1'b0;
		inA = 32'h0;
		inB = 32'h0;
		inOp = fpuOpPkg::opAdd;
		outCredit = 1'b0;
		creditMode = 1'b0;
		quietPhase = 1'b0;
		expectHead = 32'h0;
		expectCount = 0;
		opsSent = 0;
		errorCount = 0;
		testsRun = 0;
		testsFailed = 0;
		testErrors = 0;
		seed = 32'h470e_6180;
		repeat (5) @(posedge clock);
		#2;
		rst = 1'b0;

		// idle unit stays silent
		quietPhase = 1'b1;
		repeat (10) @(posedge clock);
		#2;
		quietPhase = 1'b0;
		finishTest("reset quiet");

		creditMode = 1'b1;
		sendOp(32'h3f80_0000, 32'h4000_0000, fpuOpPkg::opAdd);
		sendOp(32'h4060_0000, 32'h3fa0_0000, fpuOpPkg::opSub);
		sendOp(32'h4049_0fdb, 32'h4049_0fdb, fpuOpPkg::opSub);
		sendOp(32'h0000_0000, 32'h40a0_0000, fpuOpPkg::opAdd);
		sendOp(32'h40a0_0000, 32'h0000_0000, fpuOpPkg::opSub);
		sendOp(32'h0000_0000, 32'h0000_0000, fpuOpPkg::opSub);
		sendOp(32'hc000_0000, 32'h0000_0000, fpuOpPkg::opAdd);
		sendOp(32'h0000_0000, 32'h3f80_0000, fpuOpPkg::opSub);
		sendOp(32'h3f80_0000, 32'hbf80_0001, fpuOpPkg::opAdd);
		finishTest("directed");

		// nearby exponents for cancellation, some zero exponents
		for (int i = 0; i < RANDOM_OPS; i++)
		begin
			seed = xorshift32(seed);
			ra = seed;
			ra[30:23] = (seed[7:4] == 4'd0) ? 8'd0 : 8'd120 + 8'(seed[3:0]);
			seed = xorshift32(seed);
			rb = seed;
			rb[30:23] = (seed[7:4] == 4'd0) ? 8'd0 : 8'd120 + 8'(seed[11:8]);
			sendOp(ra, rb, fpuOpPkg::fpuOp_t'(seed[16]));
		end
		finishTest("random");

		// fill queue and pipe with grants withheld
		// the sender runs dry until the grants come back
		creditMode = 1'b0;
		#2;
		outCredit = 1'b0;
		fork
			begin
				for (int i = 0; i < HELD_OPS; i++)
				begin
					seed = xorshift32(seed);
					ra = {seed[31], 8'd127 + 8'(seed[2:0]), seed[22:0]};
					seed = xorshift32(seed);
					rb = {seed[31], 8'd126 + 8'(seed[2:0]), seed[22:0]};
					sendOp(ra, rb, fpuOpPkg::fpuOp_t'(seed[9]));
				end
			end
			begin
				repeat (HOLD_CYCLES) @(posedge clock);
				#2;
				for (int i = 0; i < HELD_OPS; i++)
				begin
					grantOne();
					repeat (2) @(posedge clock);
					#2;
				end
			end
		join
		creditMode = 1'b1;
		finishTest("withheld credits");

		$display("tests run %0d, tests failed %0d, errors %0d",
			testsRun, testsFailed, errorCount);
		if (errorCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("timeout: results did not drain within %0d cycles", WATCHDOG_CYCLES);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hdl
+incdir+bench
hdl/fpuOpPkg.sv
hdl/fpuCtlPkg.sv
hdl/fpuOperandQueue.sv
hdl/fpuAlignAdd.sv
hdl/fpuNormPack.sv
hdl/fpuAddControl.sv
hdl/fpuAddUnit.sv
bench/fpuAddUnitTb.sv

// File: Makefile
TOP = fpuAddUnitTb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJ)/V$(TOP)

$(OBJ)/V$(TOP): flist.f $(wildcard hdl/*.sv hdl/*.svh bench/*.sv bench/*.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f flist.f -o V$(TOP)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "^\*\* PASS \*\*$$" sim.log

clean:
	rm -rf $(OBJ) sim.log
